//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_core_frontend
FILELIST  := list.f
OBJ_DIR   := obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- list.f
verilog/frontend_pkg.sv
verilog/fetch_pc_gen.sv
verilog/inst_fetch.sv
verilog/inst_fifo.sv
verilog/inst_decoder.sv
verilog/core_frontend.sv
test/core_frontend_chk.sv
test/tb_core_frontend.sv

//--- test/core_frontend_chk.sv
`timescale 1ns/1ps

module core_frontend_chk (
  input logic                     clk,
  input logic                     rst_n,
  input frontend_pkg::redirect_t  redirect_i,
  input frontend_pkg::imem_req_t  req_i,
  input frontend_pkg::imem_resp_t resp_i,
  input logic [1:0]               inst_valid_i
);

  // slot 1 is never valid without slot 0
  prefix_mask: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_i != 2'b10)
    else $error("inst_valid_o is not a prefix mask");

  redirect_clears: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_i.valid |=> inst_valid_i == 2'b00)
    else $error("inst_valid_o still set in the cycle after a redirect");

  // address held until its answer arrives
  req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req_i.valid && !resp_i.valid |=> $stable(req_i.addr))
    else $error("imem_req_o changed while waiting for a response");

endmodule

bind core_frontend core_frontend_chk u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .redirect_i  (redirect_i),
  .req_i       (imem_req_o),
  .resp_i      (imem_resp_i),
  .inst_valid_i(inst_valid_o)
);

//--- test/tb_core_frontend.sv
`timescale 1ns/1ps

module tb_core_frontend;

  localparam int          FIFO_DEPTH = 16;
  localparam logic [31:0] RESET_PC   = 32'h0000_0000;
  localparam int          NUM_ROWS   = 11;
  localparam int          MIN_ISSUED = 200;

  // issue mask patterns
  localparam logic [2:0] P_ALL  = 3'd0;
  localparam logic [2:0] P_ONE  = 3'd1;
  localparam logic [2:0] P_ALT  = 3'd2;
  localparam logic [2:0] P_RAND = 3'd3;
  localparam logic [2:0] P_NONE = 3'd4;

  // one-cycle event at the start of a phase
  localparam logic [1:0] EV_NONE  = 2'd0;
  localparam logic [1:0] EV_REDIR = 2'd1;
  localparam logic [1:0] EV_WAIT  = 2'd2;
  localparam logic [1:0] EV_INT   = 2'd3;

  typedef struct packed {
    logic [15:0] len;
    logic [2:0]  pat;
    logic [1:0]  ev;
    logic [31:0] target;
  } row_t;

  logic                              clk;
  logic                              rst_n;
  frontend_pkg::redirect_t           redirect;
  logic                              wait_inst;
  logic                              irq;
  logic [1:0]                        issue;
  frontend_pkg::imem_req_t           imem_req;
  frontend_pkg::imem_resp_t          imem_resp;
  logic [1:0]                        inst_valid;
  frontend_pkg::decoded_inst_t [1:0] inst;

  logic [31:0]             imem [64];
  row_t                    rows [NUM_ROWS];
  logic                    pend_valid;
  logic [31:0]             pend_addr;
  logic [31:0]             exp_pc;
  int                      issued;
  int                      cycles;
  int                      cycle_limit;
  int unsigned             seed_init;
  frontend_pkg::redirect_t rd_ev;

  core_frontend #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .RESET_PC  (RESET_PC)
  ) uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect_i  (redirect),
    .wait_inst_i (wait_inst),
    .int_i       (irq),
    .issue_i     (issue),
    .imem_req_o  (imem_req),
    .imem_resp_i (imem_resp),
    .inst_valid_o(inst_valid),
    .inst_o      (inst)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] enc_rrr(input logic [16:0] opc, input logic [4:0] rk,
                                          input logic [4:0] rj, input logic [4:0] rd);
    return {opc, rk, rj, rd};
  endfunction

  function automatic logic [31:0] enc_ri(input logic [9:0] opc, input logic [11:0] imm,
                                         input logic [4:0] rj, input logic [4:0] rd);
    return {opc, imm, rj, rd};
  endfunction

  // word i of the program image, slot 7 of every eight is a random alu op
  function automatic logic [31:0] mem_word(input logic [5:0] i, input logic [31:0] rnd);
    case (i[2:0])
      3'd0: return enc_rrr(frontend_pkg::OPC_ADD_W, i[4:0], ~i[4:0], {i[5:2], 1'b1});
      3'd1: return enc_ri(frontend_pkg::OPC_ADDI_W, {i, i}, i[4:0], ~i[4:0]);
      3'd2: return enc_ri(frontend_pkg::OPC_LD_W, {6'h0, i}, ~i[4:0], i[5:1]);
      3'd3: return enc_ri(frontend_pkg::OPC_ST_W, {i, 6'h3}, i[5:1], i[4:0]);
      3'd4: return {frontend_pkg::OPC_BEQ, 10'h0, i, i[4:0], ~i[5:1]};
      3'd5: return {frontend_pkg::OPC_BL, 20'h0, i};
      3'd6: begin
        if (i[5]) return {frontend_pkg::OPC_IDLE, 9'h0, i};
        return enc_rrr(frontend_pkg::OPC_SUB_W, ~i[4:0], i[5:1], i[4:0]);
      end
      default: begin
        if (rnd[0]) return enc_rrr(frontend_pkg::OPC_ADD_W, rnd[5:1], rnd[10:6], rnd[15:11]);
        return enc_rrr(frontend_pkg::OPC_SUB_W, rnd[5:1], rnd[10:6], rnd[15:11]);
      end
    endcase
  endfunction

  // reference decode, unused register fields stay zero
  function automatic frontend_pkg::decoded_inst_t expect_decode(input logic [31:0] w,
                                                                input logic [31:0] pc);
    frontend_pkg::decoded_inst_t d;
    d        = '0;
    d.pc     = pc;
    d.opcode = frontend_pkg::OP_INVALID;
    d.imm    = w[25:0];
    if (w[31:15] == frontend_pkg::OPC_ADD_W || w[31:15] == frontend_pkg::OPC_SUB_W) begin
      d.opcode = (w[31:15] == frontend_pkg::OPC_ADD_W) ? frontend_pkg::OP_ADD_W
                                                        : frontend_pkg::OP_SUB_W;
      d.reg_info.r_reg[0] = w[14:10];
      d.reg_info.r_reg[1] = w[9:5];
      d.reg_info.w_reg    = w[4:0];
    end else if (w[31:15] == frontend_pkg::OPC_IDLE) begin
      d.opcode = frontend_pkg::OP_IDLE;
    end else if (w[31:22] == frontend_pkg::OPC_ADDI_W || w[31:22] == frontend_pkg::OPC_LD_W) begin
      d.opcode = (w[31:22] == frontend_pkg::OPC_LD_W) ? frontend_pkg::OP_LD_W
                                                       : frontend_pkg::OP_ADDI_W;
      d.reg_info.r_reg[1] = w[9:5];
      d.reg_info.w_reg    = w[4:0];
    end else if (w[31:22] == frontend_pkg::OPC_ST_W || w[31:26] == frontend_pkg::OPC_BEQ) begin
      d.opcode = (w[31:26] == frontend_pkg::OPC_BEQ) ? frontend_pkg::OP_BEQ
                                                      : frontend_pkg::OP_ST_W;
      d.reg_info.r_reg[0] = w[4:0];
      d.reg_info.r_reg[1] = w[9:5];
    end else if (w[31:26] == frontend_pkg::OPC_BL) begin
      d.opcode         = frontend_pkg::OP_BL;
      d.reg_info.w_reg = 5'd1;
    end
    return d;
  endfunction

  function automatic logic [1:0] pick_mask(input logic [2:0] pat, input int c);
    case (pat)
      P_ALL:  return 2'b11;
      P_ONE:  return 2'b01;
      P_ALT:  return c[0] ? 2'b01 : 2'b11;
      P_RAND: begin
        case ($urandom % 3)
          0:       return 2'b00;
          1:       return 2'b01;
          default: return 2'b11;
        endcase
      end
      default: return 2'b00;
    endcase
  endfunction

  task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s got %h expected %h", what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // drive one cycle, then score what the back end took at the negedge
  task automatic run_cycle(input logic [1:0] mask, input frontend_pkg::redirect_t rd,
                           input logic wt, input logic it);
    @(posedge clk);
    #1;
    redirect  = rd;
    wait_inst = wt;
    irq       = it;
    issue     = mask;
    @(negedge clk);
    if (imem_resp.valid) begin
      check("imem_req_o.valid", 128'(imem_req.valid), 128'd0);
    end
    // fetch always asks for a whole aligned pair
    if (imem_req.valid) begin
      check("imem_req_o.addr[2:0]", 128'(imem_req.addr[2:0]), 128'd0);
    end
    for (int s = 0; s < 2; s++) begin
      if (issue[s] && inst_valid[s]) begin
        check($sformatf("inst_o[%0d]", s), 128'(inst[s]),
              128'(expect_decode(imem[exp_pc[7:2]], exp_pc)));
        exp_pc = exp_pc + 32'd4;
        issued++;
      end
    end
    if (rd.valid) begin
      exp_pc = rd.target;
    end
  endtask

  // instruction memory, answers one cycle after it sees a request
  always @(negedge clk) begin
    pend_valid = rst_n && imem_req.valid;
    pend_addr  = imem_req.addr;
  end

  always @(posedge clk) begin
    #1;
    imem_resp.valid = pend_valid;
    imem_resp.data  = {imem[{pend_addr[7:3], 1'b1}], imem[{pend_addr[7:3], 1'b0}]};
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("Result: FAILED");
      $fatal(1, "timeout: the run did not finish within %0d cycles", cycle_limit);
    end
  end

  initial begin
    cycle_limit = 0;
    cycles      = 0;
    issued      = 0;
    rst_n       = 1'b0;
    redirect    = '0;
    wait_inst   = 1'b0;
    irq         = 1'b0;
    issue       = 2'b00;
    imem_resp   = '0;
    pend_valid  = 1'b0;
    pend_addr   = '0;
    exp_pc      = RESET_PC;
    seed_init   = $urandom(32'h66c8);
    for (int i = 0; i < 64; i++) begin
      imem[i] = mem_word(6'(i), $urandom);
    end
    rows[0]  = {16'd40, P_ALL,  EV_NONE,  32'h0};
    rows[1]  = {16'd30, P_ONE,  EV_NONE,  32'h0};
    rows[2]  = {16'd30, P_ALT,  EV_NONE,  32'h0};
    rows[3]  = {16'd30, P_NONE, EV_NONE,  32'h0};
    rows[4]  = {16'd30, P_ALL,  EV_NONE,  32'h0};
    rows[5]  = {16'd25, P_RAND, EV_REDIR, 32'h0000_0040};
    rows[6]  = {16'd25, P_ALL,  EV_REDIR, 32'h0000_0094};
    rows[7]  = {16'd40, P_RAND, EV_NONE,  32'h0};
    rows[8]  = {16'd30, P_ALL,  EV_WAIT,  32'h0};
    rows[9]  = {16'd40, P_ALT,  EV_INT,   32'h0};
    rows[10] = {16'd25, P_ONE,  EV_REDIR, 32'h0000_00fc};
    cycle_limit = 4 + 200;
    for (int r = 0; r < NUM_ROWS; r++) begin
      cycle_limit += int'(rows[r].len);
    end

    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check("inst_valid_o", 128'(inst_valid), 128'd0);
    check("imem_req_o.valid", 128'(imem_req.valid), 128'd0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int c = 0; c < int'(rows[r].len); c++) begin
        rd_ev.valid  = (c == 0) && (rows[r].ev == EV_REDIR);
        rd_ev.target = rows[r].target;
        run_cycle(rd_ev.valid ? 2'b00 : pick_mask(rows[r].pat, c), rd_ev,
                  (c == 0) && (rows[r].ev == EV_WAIT), (c == 0) && (rows[r].ev == EV_INT));
        // locked front end goes quiet once the last request is answered
        if (rows[r].ev == EV_WAIT && c >= 3) begin
          check("imem_req_o.valid", 128'(imem_req.valid), 128'd0);
        end
        if (rows[r].ev == EV_WAIT && c == int'(rows[r].len) - 1) begin
          check("inst_valid_o", 128'(inst_valid), 128'd0);
        end
      end
    end

    rd_ev = '0;
    while (issued < MIN_ISSUED) begin
      run_cycle(2'b11, rd_ev, 1'b0, 1'b0);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- verilog/core_frontend.sv
`timescale 1ns/1ps

module core_frontend #(
  parameter int          FIFO_DEPTH = 16,
  parameter logic [31:0] RESET_PC   = 32'h0000_0000
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  frontend_pkg::redirect_t           redirect_i,
  input  logic                              wait_inst_i,
  input  logic                              int_i,
  input  logic [1:0]                        issue_i,
  output frontend_pkg::imem_req_t           imem_req_o,
  input  frontend_pkg::imem_resp_t          imem_resp_i,
  output logic [1:0]                        inst_valid_o,
  output frontend_pkg::decoded_inst_t [1:0] inst_o
);

  logic                               idle_lock;
  logic [31:0]                        fetch_pc;
  logic [1:0]                         fetch_mask;
  logic                               fetch_ready;
  logic                               fifo_ready;
  logic [1:0]                         write_num;
  frontend_pkg::fetch_pkt_t [1:0]     write_pkt;
  logic [1:0]                         fifo_valid;
  logic [1:0]                         read_num;
  frontend_pkg::fetch_pkt_t [1:0]     read_pkt;
  frontend_pkg::decoded_inst_t [1:0]  dec_inst;
  logic [1:0]                         dec_valid;
  logic [1:0]                         buf_valid_q;
  logic [1:0]                         buf_valid_d;
  frontend_pkg::decoded_inst_t [1:0]  buf_q;
  frontend_pkg::decoded_inst_t [1:0]  buf_d;
  logic [1:0]                         vld_num;
  logic [1:0]                         acc_num;
  logic [1:0]                         rem_num;

  // fetch sleeps after a wait instruction until an interrupt shows up
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_lock <= 1'b0;
    end else if (wait_inst_i && !int_i) begin
      idle_lock <= 1'b1;
    end else if (int_i) begin
      idle_lock <= 1'b0;
    end
  end

  fetch_pc_gen #(
    .RESET_PC(RESET_PC)
  ) u_pc_gen (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect_i),
    .stall_i      (idle_lock),
    .fetch_ready_i(fetch_ready),
    .pc_o         (fetch_pc),
    .slot_mask_o  (fetch_mask)
  );

  inst_fetch u_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .redirect_i   (redirect_i),
    .stall_i      (idle_lock),
    .pc_i         (fetch_pc),
    .slot_mask_i  (fetch_mask),
    .fetch_ready_o(fetch_ready),
    .imem_req_o   (imem_req_o),
    .imem_resp_i  (imem_resp_i),
    .fifo_ready_i (fifo_ready),
    .write_num_o  (write_num),
    .write_data_o (write_pkt)
  );

  inst_fifo #(
    .DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i.valid),
    .write_num_i  (write_num),
    .write_data_i (write_pkt),
    .write_ready_o(fifo_ready),
    .read_valid_o (fifo_valid),
    .read_num_i   (read_num),
    .read_data_o  (read_pkt)
  );

  for (genvar i = 0; i < 2; i++) begin : g_dec
    inst_decoder u_dec (
      .inst_i   (read_pkt[i].inst),
      .pc_i     (read_pkt[i].pc),
      .decoded_o(dec_inst[i])
    );
  end

  assign dec_valid = fifo_valid & {2{~redirect_i.valid}};

  // occupancy, accepted entries and what stays behind
  always_comb begin
    vld_num = {1'b0, buf_valid_q[0]} + {1'b0, buf_valid_q[1]};
    acc_num = {1'b0, issue_i[0] & buf_valid_q[0]} + {1'b0, issue_i[1] & buf_valid_q[1]};
    rem_num = vld_num - acc_num;
  end

  // refill from the decoders in program order
  always_comb begin
    buf_valid_d = buf_valid_q;
    buf_d       = buf_q;
    read_num    = 2'd0;
    case (rem_num)
      2'd0: begin
        buf_valid_d = dec_valid;
        buf_d       = dec_inst;
        read_num    = {1'b0, dec_valid[0]} + {1'b0, dec_valid[1]};
      end
      2'd1: begin
        // survivor shifts down to slot 0
        buf_valid_d = {dec_valid[0], 1'b1};
        buf_d[0]    = buf_q[acc_num[0]];
        buf_d[1]    = dec_inst[0];
        read_num    = {1'b0, dec_valid[0]};
      end
      default: begin
        buf_valid_d = buf_valid_q;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || redirect_i.valid) begin
      buf_valid_q <= 2'b00;
    end else begin
      buf_valid_q <= buf_valid_d;
    end
  end

  always_ff @(posedge clk) begin
    buf_q <= buf_d;
  end

  assign inst_valid_o = buf_valid_q;
  assign inst_o       = buf_q;

endmodule

//--- verilog/fetch_pc_gen.sv
`timescale 1ns/1ps

module fetch_pc_gen #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  frontend_pkg::redirect_t redirect_i,
  input  logic                    stall_i,
  input  logic                    fetch_ready_i,
  output logic [31:0]             pc_o,
  output logic [1:0]              slot_mask_o
);

  logic [31:0] pc_q;
  logic [1:0]  mask_q;

  // pair-aligned pc, slot 0 masked when entering on an odd word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q   <= {RESET_PC[31:3], 3'b000};
      mask_q <= RESET_PC[2] ? 2'b10 : 2'b11;
    end else if (redirect_i.valid) begin
      pc_q   <= {redirect_i.target[31:3], 3'b000};
      mask_q <= redirect_i.target[2] ? 2'b10 : 2'b11;
    end else if (fetch_ready_i && !stall_i) begin
      // next pair, both slots live
      pc_q   <= pc_q + 32'd8;
      mask_q <= 2'b11;
    end
  end

  assign pc_o        = pc_q;
  assign slot_mask_o = mask_q;

endmodule

//--- verilog/frontend_pkg.sv
package frontend_pkg;

  // decoded operations
  typedef enum logic [3:0] {
    OP_ADD_W,
    OP_SUB_W,
    OP_ADDI_W,
    OP_LD_W,
    OP_ST_W,
    OP_BEQ,
    OP_BL,
    OP_IDLE,
    OP_INVALID
  } opcode_e;

  // where a register index comes from
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_RK,
    SEL_RD,
    SEL_RJ,
    SEL_RJD,
    SEL_R1
  } reg_sel_e;

  // major opcode fields, inst[31:15]
  localparam logic [16:0] OPC_ADD_W  = 17'h00020;
  localparam logic [16:0] OPC_SUB_W  = 17'h00022;
  localparam logic [16:0] OPC_IDLE   = 17'h00c91;
  // inst[31:22]
  localparam logic [9:0]  OPC_ADDI_W = 10'h00a;
  localparam logic [9:0]  OPC_LD_W   = 10'h0a2;
  localparam logic [9:0]  OPC_ST_W   = 10'h0a6;
  // inst[31:26]
  localparam logic [5:0]  OPC_BEQ    = 6'h16;
  localparam logic [5:0]  OPC_BL     = 6'h15;

  typedef struct packed {
    logic [1:0][4:0] r_reg;
    logic [4:0]      w_reg;
  } reg_info_t;

  typedef struct packed {
    logic [31:0] pc;
    opcode_e     opcode;
    reg_info_t   reg_info;
    logic [25:0] imm;
  } decoded_inst_t;

  // one fifo entry
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } imem_req_t;

  // low word is the even-word instruction
  typedef struct packed {
    logic        valid;
    logic [63:0] data;
  } imem_resp_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } redirect_t;

  function automatic logic [4:0] sel_reg(reg_sel_e sel, logic [31:0] inst);
    case (sel)
      SEL_RK:  return inst[14:10];
      SEL_RD:  return inst[4:0];
      SEL_RJ:  return inst[9:5];
      SEL_RJD: return inst[4:0] | inst[9:5];
      SEL_R1:  return 5'd1;
      default: return 5'd0;
    endcase
  endfunction

  function automatic reg_info_t get_register_info(reg_sel_e r0_sel, reg_sel_e r1_sel,
                                                  reg_sel_e w_sel, logic [31:0] inst);
    reg_info_t ret;
    ret.r_reg[0] = sel_reg(r0_sel, inst);
    ret.r_reg[1] = sel_reg(r1_sel, inst);
    ret.w_reg    = sel_reg(w_sel, inst);
    return ret;
  endfunction

endpackage

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
  input  logic [31:0]                 inst_i,
  input  logic [31:0]                 pc_i,
  output frontend_pkg::decoded_inst_t decoded_o
);

  frontend_pkg::opcode_e  op;
  frontend_pkg::reg_sel_e r0_sel;
  frontend_pkg::reg_sel_e r1_sel;
  frontend_pkg::reg_sel_e w_sel;

  always_comb begin
    op     = frontend_pkg::OP_INVALID;
    r0_sel = frontend_pkg::SEL_NONE;
    r1_sel = frontend_pkg::SEL_NONE;
    w_sel  = frontend_pkg::SEL_NONE;
    if (inst_i[31:15] == frontend_pkg::OPC_ADD_W) begin
      op     = frontend_pkg::OP_ADD_W;
      r0_sel = frontend_pkg::SEL_RK;
      r1_sel = frontend_pkg::SEL_RJ;
      w_sel  = frontend_pkg::SEL_RD;
    end else if (inst_i[31:15] == frontend_pkg::OPC_SUB_W) begin
      op     = frontend_pkg::OP_SUB_W;
      r0_sel = frontend_pkg::SEL_RK;
      r1_sel = frontend_pkg::SEL_RJ;
      w_sel  = frontend_pkg::SEL_RD;
    end else if (inst_i[31:15] == frontend_pkg::OPC_IDLE) begin
      op = frontend_pkg::OP_IDLE;
    end else if (inst_i[31:22] == frontend_pkg::OPC_ADDI_W) begin
      op     = frontend_pkg::OP_ADDI_W;
      r1_sel = frontend_pkg::SEL_RJ;
      w_sel  = frontend_pkg::SEL_RD;
    end else if (inst_i[31:22] == frontend_pkg::OPC_LD_W) begin
      op     = frontend_pkg::OP_LD_W;
      r1_sel = frontend_pkg::SEL_RJ;
      w_sel  = frontend_pkg::SEL_RD;
    end else if (inst_i[31:22] == frontend_pkg::OPC_ST_W) begin
      // store data comes through rd
      op     = frontend_pkg::OP_ST_W;
      r0_sel = frontend_pkg::SEL_RD;
      r1_sel = frontend_pkg::SEL_RJ;
    end else if (inst_i[31:26] == frontend_pkg::OPC_BEQ) begin
      op     = frontend_pkg::OP_BEQ;
      r0_sel = frontend_pkg::SEL_RD;
      r1_sel = frontend_pkg::SEL_RJ;
    end else if (inst_i[31:26] == frontend_pkg::OPC_BL) begin
      // link into r1
      op    = frontend_pkg::OP_BL;
      w_sel = frontend_pkg::SEL_R1;
    end
  end

  always_comb begin
    decoded_o.pc       = pc_i;
    decoded_o.opcode   = op;
    decoded_o.reg_info = frontend_pkg::get_register_info(r0_sel, r1_sel, w_sel, inst_i);
    decoded_o.imm      = inst_i[25:0];
  end

endmodule

//--- verilog/inst_fetch.sv
`timescale 1ns/1ps

module inst_fetch (
  input  logic                           clk,
  input  logic                           rst_n,
  input  frontend_pkg::redirect_t        redirect_i,
  input  logic                           stall_i,
  input  logic [31:0]                    pc_i,
  input  logic [1:0]                     slot_mask_i,
  output logic                           fetch_ready_o,
  output frontend_pkg::imem_req_t        imem_req_o,
  input  frontend_pkg::imem_resp_t       imem_resp_i,
  input  logic                           fifo_ready_i,
  output logic [1:0]                     write_num_o,
  output frontend_pkg::fetch_pkt_t [1:0] write_data_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_RESP,
    HOLD
  } state_e;

  state_e      state;
  logic        req_valid_q;
  logic        stale_q;
  logic [31:0] req_addr_q;
  logic [1:0]  req_mask_q;
  logic [63:0] data_q;
  logic        drain;
  logic        start;

  // held pair goes to the fifo this cycle
  assign drain         = (state == HOLD) && fifo_ready_i && !redirect_i.valid;
  assign fetch_ready_o = !redirect_i.valid && ((state == IDLE) || drain);
  assign start         = fetch_ready_o && !stall_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= IDLE;
      req_valid_q <= 1'b0;
      stale_q     <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state       <= WAIT_RESP;
            req_valid_q <= 1'b1;
          end
        end
        WAIT_RESP: begin
          if (imem_resp_i.valid) begin
            req_valid_q <= 1'b0;
            stale_q     <= 1'b0;
            // response of a request issued before a redirect is dropped
            state       <= (stale_q || redirect_i.valid) ? IDLE : HOLD;
          end else if (redirect_i.valid) begin
            stale_q <= 1'b1;
          end
        end
        HOLD: begin
          if (start) begin
            state       <= WAIT_RESP;
            req_valid_q <= 1'b1;
          end else if (redirect_i.valid || drain) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req_addr_q <= pc_i;
      req_mask_q <= slot_mask_i;
    end
    if (state == WAIT_RESP && imem_resp_i.valid) begin
      data_q <= imem_resp_i.data;
    end
  end

  // request drops as soon as its answer shows up
  assign imem_req_o.valid = req_valid_q && !imem_resp_i.valid;
  assign imem_req_o.addr  = req_addr_q;

  assign write_num_o = drain ? ({1'b0, req_mask_q[0]} + {1'b0, req_mask_q[1]}) : 2'd0;

  // compact, older valid slot goes first
  always_comb begin
    write_data_o[0].pc   = {req_addr_q[31:3], !req_mask_q[0], 2'b00};
    write_data_o[0].inst = req_mask_q[0] ? data_q[31:0] : data_q[63:32];
    write_data_o[1].pc   = {req_addr_q[31:3], 3'b100};
    write_data_o[1].inst = data_q[63:32];
  end

endmodule

//--- verilog/inst_fifo.sv
`timescale 1ns/1ps

module inst_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           flush_i,
  input  logic [1:0]                     write_num_i,
  input  frontend_pkg::fetch_pkt_t [1:0] write_data_i,
  output logic                           write_ready_o,
  output logic [1:0]                     read_valid_o,
  input  logic [1:0]                     read_num_i,
  output frontend_pkg::fetch_pkt_t [1:0] read_data_o
);

  localparam int AW         = $clog2(DEPTH);
  localparam int BANK_DEPTH = DEPTH / 2;

  // entry i sits in bank i[0], row i[AW-1:1]
  frontend_pkg::fetch_pkt_t bank_mem [2][BANK_DEPTH];

  logic [AW-1:0]      wr_ptr;
  logic [AW-1:0]      rd_ptr;
  logic [AW:0]        count;
  logic [1:0][AW-1:0] wr_idx;
  logic [1:0][AW-1:0] rd_idx;

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      wr_idx[s] = wr_ptr + AW'(s);
      rd_idx[s] = rd_ptr + AW'(s);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + AW'(write_num_i);
      rd_ptr <= rd_ptr + AW'(read_num_i);
      count  <= count + (AW+1)'(write_num_i) - (AW+1)'(read_num_i);
    end
  end

  // consecutive writes always land in different banks
  always_ff @(posedge clk) begin
    for (int s = 0; s < 2; s++) begin
      if (!flush_i && s < int'(write_num_i)) begin
        bank_mem[wr_idx[s][0]][wr_idx[s][AW-1:1]] <= write_data_i[s];
      end
    end
  end

  // room for a full pair
  assign write_ready_o = count <= (AW+1)'(DEPTH - 2);

  assign read_valid_o[0] = count != '0;
  assign read_valid_o[1] = count >= (AW+1)'(2);

  always_comb begin
    for (int r = 0; r < 2; r++) begin
      read_data_o[r] = bank_mem[rd_idx[r][0]][rd_idx[r][AW-1:1]];
    end
  end

endmodule
